// File: hw/controlUnit_cfg.svh
`ifndef CONTROL_UNIT_CFG_SVH
`define CONTROL_UNIT_CFG_SVH

// Instruction register width
`define OPCODE_WIDTH 8

// Registers under control of the mask words
`define REG_COUNT 14

// Bit position of each register in the write, increment and reset masks
`define REG_PC   0
`define REG_IR   1
`define REG_GSP  2
`define REG_RP   3
`define REG_CP   4
`define REG_STP  5
`define REG_CID  6
`define REG_EOPC 7
`define REG_MC   8
`define REG_MV   9
`define REG_WV   10
`define REG_MULR 11
`define REG_ADDR 12
`define REG_AC   13

`endif

// File: hw/controlPkg.sv
`include "controlUnit_cfg.svh"

package controlPkg;

	// One enable bit per register
	typedef logic [`REG_COUNT-1:0] regMaskT;

	typedef enum logic [`OPCODE_WIDTH-1:0] {
		OP_RSTALL = 8'd1, OP_RSTAC, OP_RSTADDR, OP_RSTGSP, OP_RSTMC, OP_RSTCP, OP_RSTRP,
		OP_INCGSP, OP_INCAC, OP_INCCP, OP_INCRP, OP_INCMC, OP_INCSTP,
		OP_MSTP, OP_MRP, OP_MCP, OP_MEOPC, OP_MADDR, OP_MCID,
		OP_MCIDAC, OP_MRPAC, OP_MCPAC, OP_MSTPAC,
		OP_LDADDR, OP_LDAC, OP_LDRP, OP_LDCP,
		OP_STSP,
		OP_ADD,
		OP_JMPZ1, OP_JMPZ2, OP_JMP,
		OP_END
	} opcodeT;

	typedef enum logic [7:0] {
		ST_FETCH1, ST_FETCH2,
		// Single-cycle instructions
		ST_RSTALL, ST_RSTAC, ST_RSTADDR, ST_RSTGSP, ST_RSTMC, ST_RSTCP, ST_RSTRP,
		ST_INCGSP, ST_INCAC, ST_INCCP, ST_INCRP, ST_INCMC, ST_INCSTP,
		ST_MSTP, ST_MRP, ST_MCP, ST_MEOPC, ST_MADDR, ST_MCID,
		ST_MCIDAC, ST_MRPAC, ST_MCPAC, ST_MSTPAC,
		ST_ADD,
		// Memory loads and store
		ST_LDADDR1, ST_LDADDR2, ST_LDAC1, ST_LDAC2,
		ST_LDRP1, ST_LDRP2, ST_LDCP1, ST_LDCP2,
		ST_STSP,
		// Conditional and unconditional jumps
		ST_JMPZ1, ST_JMPZ1Y1, ST_JMPZ1Y2, ST_JMPZ1Y3, ST_JMPZ1N1, ST_JMPZ1N2,
		ST_JMPZ2, ST_JMPZ2Y1, ST_JMPZ2Y2, ST_JMPZ2Y3, ST_JMPZ2N1, ST_JMPZ2N2,
		ST_JMP1, ST_JMP2, ST_JMP3, ST_JMP4,
		ST_HALT
	} ctrlStateT;

	typedef enum logic [1:0] {
		ALU_NONE,
		ALU_ADD
	} aluOpT;

	typedef enum logic [2:0] {
		BS_AC, BS_MEMOUT, BS_ADDR, BS_CID, BS_RP, BS_CP, BS_STP
	} busSelectT;

	typedef enum logic [1:0] {
		PTR_GSP, PTR_RP, PTR_CP, PTR_STP
	} pointerSelectT;

	typedef enum logic [1:0] {
		MEM_IDLE, MEM_IREAD, MEM_READ, MEM_WRITE
	} memCtrlT;

	typedef struct packed {
		aluOpT aluOp;
		busSelectT busSelect;
		pointerSelectT pointerSelect;
		memCtrlT memCtrl;
		regMaskT wrtEn;
		regMaskT incEn;
		regMaskT rstEn;
	} controlWordT;

endpackage

// File: hw/opcodeDecoder.sv
`timescale 1ns/1ps

module opcodeDecoder (
	input controlPkg::opcodeT ins,
	output controlPkg::ctrlStateT entryState
);

	always_comb begin
		case (ins)
			controlPkg::OP_RSTALL: entryState = controlPkg::ST_RSTALL;
			controlPkg::OP_RSTAC: entryState = controlPkg::ST_RSTAC;
			controlPkg::OP_RSTADDR: entryState = controlPkg::ST_RSTADDR;
			controlPkg::OP_RSTGSP: entryState = controlPkg::ST_RSTGSP;
			controlPkg::OP_RSTMC: entryState = controlPkg::ST_RSTMC;
			controlPkg::OP_RSTCP: entryState = controlPkg::ST_RSTCP;
			controlPkg::OP_RSTRP: entryState = controlPkg::ST_RSTRP;

			controlPkg::OP_INCGSP: entryState = controlPkg::ST_INCGSP;
			controlPkg::OP_INCAC: entryState = controlPkg::ST_INCAC;
			controlPkg::OP_INCCP: entryState = controlPkg::ST_INCCP;
			controlPkg::OP_INCRP: entryState = controlPkg::ST_INCRP;
			controlPkg::OP_INCMC: entryState = controlPkg::ST_INCMC;
			controlPkg::OP_INCSTP: entryState = controlPkg::ST_INCSTP;

			controlPkg::OP_MSTP: entryState = controlPkg::ST_MSTP;
			controlPkg::OP_MRP: entryState = controlPkg::ST_MRP;
			controlPkg::OP_MCP: entryState = controlPkg::ST_MCP;
			controlPkg::OP_MEOPC: entryState = controlPkg::ST_MEOPC;
			controlPkg::OP_MADDR: entryState = controlPkg::ST_MADDR;
			controlPkg::OP_MCID: entryState = controlPkg::ST_MCID;

			controlPkg::OP_MCIDAC: entryState = controlPkg::ST_MCIDAC;
			controlPkg::OP_MRPAC: entryState = controlPkg::ST_MRPAC;
			controlPkg::OP_MCPAC: entryState = controlPkg::ST_MCPAC;
			controlPkg::OP_MSTPAC: entryState = controlPkg::ST_MSTPAC;

			// Loads start with the memory read
			controlPkg::OP_LDADDR: entryState = controlPkg::ST_LDADDR1;
			controlPkg::OP_LDAC: entryState = controlPkg::ST_LDAC1;
			controlPkg::OP_LDRP: entryState = controlPkg::ST_LDRP1;
			controlPkg::OP_LDCP: entryState = controlPkg::ST_LDCP1;
			controlPkg::OP_STSP: entryState = controlPkg::ST_STSP;

			controlPkg::OP_ADD: entryState = controlPkg::ST_ADD;

			controlPkg::OP_JMPZ1: entryState = controlPkg::ST_JMPZ1;
			controlPkg::OP_JMPZ2: entryState = controlPkg::ST_JMPZ2;
			controlPkg::OP_JMP: entryState = controlPkg::ST_JMP1;

			controlPkg::OP_END: entryState = controlPkg::ST_HALT;
			// Unknown opcodes stop the processor too
			default: entryState = controlPkg::ST_HALT;
		endcase
	end

endmodule

// File: hw/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer (
	input logic clk,
	input logic reset,
	input logic acq,
	input logic z1,
	input logic z2,
	input controlPkg::ctrlStateT entryState,
	output controlPkg::ctrlStateT state
);

	controlPkg::ctrlStateT nextState;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= controlPkg::ST_FETCH1;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		case (state)
			// Instruction fetch waits for the memory
			controlPkg::ST_FETCH1:
				nextState = acq ? controlPkg::ST_FETCH2 : controlPkg::ST_FETCH1;
			controlPkg::ST_FETCH2:
				nextState = entryState;

			controlPkg::ST_LDADDR1:
				nextState = acq ? controlPkg::ST_LDADDR2 : controlPkg::ST_LDADDR1;
			controlPkg::ST_LDAC1:
				nextState = acq ? controlPkg::ST_LDAC2 : controlPkg::ST_LDAC1;
			controlPkg::ST_LDRP1:
				nextState = acq ? controlPkg::ST_LDRP2 : controlPkg::ST_LDRP1;
			controlPkg::ST_LDCP1:
				nextState = acq ? controlPkg::ST_LDCP2 : controlPkg::ST_LDCP1;
			// Store finishes as soon as the write is acknowledged
			controlPkg::ST_STSP:
				nextState = acq ? controlPkg::ST_FETCH1 : controlPkg::ST_STSP;

			// Jump taken when z1 is set
			controlPkg::ST_JMPZ1:
				nextState = z1 ? controlPkg::ST_JMPZ1Y1 : controlPkg::ST_JMPZ1N1;
			controlPkg::ST_JMPZ1Y1: nextState = controlPkg::ST_JMPZ1Y2;
			controlPkg::ST_JMPZ1Y2: nextState = controlPkg::ST_JMPZ1Y3;
			controlPkg::ST_JMPZ1Y3: nextState = controlPkg::ST_FETCH1;
			controlPkg::ST_JMPZ1N1: nextState = controlPkg::ST_JMPZ1N2;
			controlPkg::ST_JMPZ1N2: nextState = controlPkg::ST_FETCH1;

			// Jump taken when z2 is clear
			controlPkg::ST_JMPZ2:
				nextState = !z2 ? controlPkg::ST_JMPZ2Y1 : controlPkg::ST_JMPZ2N1;
			controlPkg::ST_JMPZ2Y1: nextState = controlPkg::ST_JMPZ2Y2;
			controlPkg::ST_JMPZ2Y2: nextState = controlPkg::ST_JMPZ2Y3;
			controlPkg::ST_JMPZ2Y3: nextState = controlPkg::ST_FETCH1;
			controlPkg::ST_JMPZ2N1: nextState = controlPkg::ST_JMPZ2N2;
			controlPkg::ST_JMPZ2N2: nextState = controlPkg::ST_FETCH1;

			controlPkg::ST_JMP1: nextState = controlPkg::ST_JMP2;
			controlPkg::ST_JMP2: nextState = controlPkg::ST_JMP3;
			controlPkg::ST_JMP3: nextState = controlPkg::ST_JMP4;
			controlPkg::ST_JMP4: nextState = controlPkg::ST_FETCH1;

			// Only reset leaves halt
			controlPkg::ST_HALT: nextState = controlPkg::ST_HALT;

			// Single-cycle instructions and load completions
			default: nextState = controlPkg::ST_FETCH1;
		endcase
	end

endmodule

// File: hw/controlWordTable.sv
`timescale 1ns/1ps
`include "controlUnit_cfg.svh"

module controlWordTable (
	input controlPkg::ctrlStateT state,
	output controlPkg::controlWordT ctrl
);

	always_comb begin
		// Idle word, overridden below per state
		ctrl.aluOp = controlPkg::ALU_NONE;
		ctrl.busSelect = controlPkg::BS_AC;
		ctrl.pointerSelect = controlPkg::PTR_GSP;
		ctrl.memCtrl = controlPkg::MEM_IDLE;
		ctrl.wrtEn = '0;
		ctrl.incEn = '0;
		ctrl.rstEn = '0;

		case (state)
			controlPkg::ST_FETCH1: begin
				ctrl.memCtrl = controlPkg::MEM_IREAD;
			end
			controlPkg::ST_FETCH2: begin
				ctrl.incEn[`REG_PC] = 1'b1;
				ctrl.wrtEn[`REG_IR] = 1'b1;
			end

			// PC and IR are left alone by reset-all
			controlPkg::ST_RSTALL: begin
				ctrl.rstEn[`REG_AC:`REG_GSP] = '1;
			end
			controlPkg::ST_RSTAC: ctrl.rstEn[`REG_AC] = 1'b1;
			controlPkg::ST_RSTADDR: ctrl.rstEn[`REG_ADDR] = 1'b1;
			controlPkg::ST_RSTGSP: ctrl.rstEn[`REG_GSP] = 1'b1;
			controlPkg::ST_RSTMC: ctrl.rstEn[`REG_MC] = 1'b1;
			controlPkg::ST_RSTCP: ctrl.rstEn[`REG_CP] = 1'b1;
			controlPkg::ST_RSTRP: ctrl.rstEn[`REG_RP] = 1'b1;

			controlPkg::ST_INCGSP: ctrl.incEn[`REG_GSP] = 1'b1;
			controlPkg::ST_INCAC: ctrl.incEn[`REG_AC] = 1'b1;
			controlPkg::ST_INCCP: ctrl.incEn[`REG_CP] = 1'b1;
			controlPkg::ST_INCRP: ctrl.incEn[`REG_RP] = 1'b1;
			controlPkg::ST_INCMC: ctrl.incEn[`REG_MC] = 1'b1;
			controlPkg::ST_INCSTP: ctrl.incEn[`REG_STP] = 1'b1;

			// Accumulator drives the bus into the target
			controlPkg::ST_MSTP: begin
				ctrl.busSelect = controlPkg::BS_AC;
				ctrl.wrtEn[`REG_STP] = 1'b1;
			end
			controlPkg::ST_MRP: begin
				ctrl.busSelect = controlPkg::BS_AC;
				ctrl.wrtEn[`REG_RP] = 1'b1;
			end
			controlPkg::ST_MCP: begin
				ctrl.busSelect = controlPkg::BS_AC;
				ctrl.wrtEn[`REG_CP] = 1'b1;
			end
			controlPkg::ST_MEOPC: begin
				ctrl.busSelect = controlPkg::BS_AC;
				ctrl.wrtEn[`REG_EOPC] = 1'b1;
			end
			controlPkg::ST_MADDR: begin
				ctrl.busSelect = controlPkg::BS_AC;
				ctrl.wrtEn[`REG_ADDR] = 1'b1;
			end
			controlPkg::ST_MCID: begin
				ctrl.busSelect = controlPkg::BS_AC;
				ctrl.wrtEn[`REG_CID] = 1'b1;
			end

			controlPkg::ST_MCIDAC: begin
				ctrl.busSelect = controlPkg::BS_CID;
				ctrl.wrtEn[`REG_AC] = 1'b1;
			end
			controlPkg::ST_MRPAC: begin
				ctrl.busSelect = controlPkg::BS_RP;
				ctrl.wrtEn[`REG_AC] = 1'b1;
			end
			controlPkg::ST_MCPAC: begin
				ctrl.busSelect = controlPkg::BS_CP;
				ctrl.wrtEn[`REG_AC] = 1'b1;
			end
			controlPkg::ST_MSTPAC: begin
				ctrl.busSelect = controlPkg::BS_STP;
				ctrl.wrtEn[`REG_AC] = 1'b1;
			end

			controlPkg::ST_LDADDR1, controlPkg::ST_LDAC1: begin
				ctrl.memCtrl = controlPkg::MEM_READ;
			end
			controlPkg::ST_LDRP1: begin
				ctrl.memCtrl = controlPkg::MEM_READ;
				ctrl.pointerSelect = controlPkg::PTR_RP;
			end
			controlPkg::ST_LDCP1: begin
				ctrl.memCtrl = controlPkg::MEM_READ;
				ctrl.pointerSelect = controlPkg::PTR_CP;
			end
			controlPkg::ST_LDADDR2: begin
				ctrl.busSelect = controlPkg::BS_MEMOUT;
				ctrl.wrtEn[`REG_ADDR] = 1'b1;
			end
			// LDCP lands its data in AC as well
			controlPkg::ST_LDAC2, controlPkg::ST_LDCP2: begin
				ctrl.busSelect = controlPkg::BS_MEMOUT;
				ctrl.wrtEn[`REG_AC] = 1'b1;
			end
			controlPkg::ST_LDRP2: begin
				ctrl.busSelect = controlPkg::BS_MEMOUT;
				ctrl.wrtEn[`REG_RP] = 1'b1;
			end
			controlPkg::ST_STSP: begin
				ctrl.memCtrl = controlPkg::MEM_WRITE;
				ctrl.pointerSelect = controlPkg::PTR_STP;
			end

			controlPkg::ST_ADD: begin
				ctrl.aluOp = controlPkg::ALU_ADD;
				ctrl.busSelect = controlPkg::BS_ADDR;
			end

			// Target address comes in through IR, then moves to PC
			controlPkg::ST_JMPZ1Y1, controlPkg::ST_JMPZ2Y1: begin
				ctrl.wrtEn[`REG_IR] = 1'b1;
			end
			controlPkg::ST_JMPZ1Y2, controlPkg::ST_JMPZ2Y2, controlPkg::ST_JMP3: begin
				ctrl.wrtEn[`REG_PC] = 1'b1;
			end
			// Skip over the jump target
			controlPkg::ST_JMPZ1N1, controlPkg::ST_JMPZ2N1: begin
				ctrl.incEn[`REG_PC] = 1'b1;
				ctrl.wrtEn[`REG_IR] = 1'b1;
			end

			default: begin
				ctrl.memCtrl = controlPkg::MEM_IDLE;
			end
		endcase
	end

endmodule

// File: hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input logic clk,
	input logic reset,
	input controlPkg::opcodeT ins,
	input logic acq,
	input logic z1,
	input logic z2,
	output controlPkg::controlWordT ctrl
);

	controlPkg::ctrlStateT entryState;
	controlPkg::ctrlStateT state;

	opcodeDecoder opcodeDecoder_i (
		.ins(ins),
		.entryState(entryState)
	);

	controlSequencer controlSequencer_i (
		.clk(clk),
		.reset(reset),
		.acq(acq),
		.z1(z1),
		.z2(z2),
		.entryState(entryState),
		.state(state)
	);

	// Moore outputs straight from the current state
	controlWordTable controlWordTable_i (
		.state(state),
		.ctrl(ctrl)
	);

endmodule

// File: verification/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;

	logic clk;
	logic reset;
	controlPkg::opcodeT ins;
	logic acq;
	logic z1;
	logic z2;
	controlPkg::controlWordT ctrl;

	// One entry per clock cycle of the trace
	string nameQ[$];
	logic [11:0] inputQ[$];
	controlPkg::controlWordT expectQ[$];

	logic traceReady;
	int errorCount;
	int testErrors;
	int testsPassed;
	int testsFailed;

	controlUnit controlUnit_i (
		.clk(clk),
		.reset(reset),
		.ins(ins),
		.acq(acq),
		.z1(z1),
		.z2(z2),
		.ctrl(ctrl)
	);

	always #5 clk = ~clk;

	task automatic loadTrace();
		integer fd;
		integer code;
		integer fields;
		string line;
		string name;
		integer rstV, insV, acqV, z1V, z2V;
		integer aluV, busV, ptrV, memV, wrtV, incV, rstMaskV;
		controlPkg::controlWordT word;
		fd = $fopen("verification/controlUnit_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				// Skip blank lines and column notes
				if (code > 0 && line.substr(0, 0) != "#") begin
					fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h",
						name, rstV, insV, acqV, z1V, z2V,
						aluV, busV, ptrV, memV, wrtV, incV, rstMaskV);
					if (fields == 13) begin
						word.aluOp = controlPkg::aluOpT'(aluV);
						word.busSelect = controlPkg::busSelectT'(busV);
						word.pointerSelect = controlPkg::pointerSelectT'(ptrV);
						word.memCtrl = controlPkg::memCtrlT'(memV);
						word.wrtEn = controlPkg::regMaskT'(wrtV);
						word.incEn = controlPkg::regMaskT'(incV);
						word.rstEn = controlPkg::regMaskT'(rstMaskV);
						nameQ.push_back(name);
						inputQ.push_back({rstV[0], insV[7:0], acqV[0], z1V[0], z2V[0]});
						expectQ.push_back(word);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic countMismatch();
		errorCount++;
		testErrors++;
	endtask

	task automatic checkAluOp(input string testName, input controlPkg::aluOpT expected,
			input controlPkg::aluOpT actual);
		if (actual !== expected) begin
			$display("ERR %s aluOp at %0t expected %s actual %s",
				testName, $time, expected.name(), actual.name());
			countMismatch();
		end
	endtask

	task automatic checkBusSelect(input string testName, input controlPkg::busSelectT expected,
			input controlPkg::busSelectT actual);
		if (actual !== expected) begin
			$display("ERR %s busSelect at %0t expected %s actual %s",
				testName, $time, expected.name(), actual.name());
			countMismatch();
		end
	endtask

	task automatic checkPointerSelect(input string testName,
			input controlPkg::pointerSelectT expected, input controlPkg::pointerSelectT actual);
		if (actual !== expected) begin
			$display("ERR %s pointerSelect at %0t expected %s actual %s",
				testName, $time, expected.name(), actual.name());
			countMismatch();
		end
	endtask

	task automatic checkMemCtrl(input string testName, input controlPkg::memCtrlT expected,
			input controlPkg::memCtrlT actual);
		if (actual !== expected) begin
			$display("ERR %s memCtrl at %0t expected %s actual %s",
				testName, $time, expected.name(), actual.name());
			countMismatch();
		end
	endtask

	task automatic checkRegMask(input string testName, input string field,
			input controlPkg::regMaskT expected, input controlPkg::regMaskT actual);
		if (actual !== expected) begin
			$display("ERR %s %s at %0t expected %h actual %h",
				testName, field, $time, expected, actual);
			countMismatch();
		end
	endtask

	task automatic driveInputs(input int idx);
		reset = inputQ[idx][11];
		ins = controlPkg::opcodeT'(inputQ[idx][10:3]);
		acq = inputQ[idx][2];
		z1 = inputQ[idx][1];
		z2 = inputQ[idx][0];
	endtask

	task automatic checkCycle(input int idx);
		checkAluOp(nameQ[idx], expectQ[idx].aluOp, ctrl.aluOp);
		checkBusSelect(nameQ[idx], expectQ[idx].busSelect, ctrl.busSelect);
		checkPointerSelect(nameQ[idx], expectQ[idx].pointerSelect, ctrl.pointerSelect);
		checkMemCtrl(nameQ[idx], expectQ[idx].memCtrl, ctrl.memCtrl);
		checkRegMask(nameQ[idx], "wrtEn", expectQ[idx].wrtEn, ctrl.wrtEn);
		checkRegMask(nameQ[idx], "incEn", expectQ[idx].incEn, ctrl.incEn);
		checkRegMask(nameQ[idx], "rstEn", expectQ[idx].rstEn, ctrl.rstEn);
	endtask

	task automatic reportTest(input string testName);
		if (testErrors == 0) begin
			testsPassed++;
			$display("PASS %s", testName);
		end else begin
			testsFailed++;
			$display("FAIL %s with %0d mismatches", testName, testErrors);
		end
		testErrors = 0;
	endtask

	task automatic runTrace();
		string current;
		current = nameQ[0];
		for (int i = 0; i < nameQ.size(); i++) begin
			if (nameQ[i] != current) begin
				reportTest(current);
				current = nameQ[i];
			end
			#1;
			driveInputs(i);
			// Sample just before the next rising edge
			#7;
			checkCycle(i);
			@(posedge clk);
		end
		reportTest(current);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		ins = controlPkg::opcodeT'(8'h00);
		acq = 1'b0;
		z1 = 1'b0;
		z2 = 1'b0;
		traceReady = 1'b0;
		errorCount = 0;
		testErrors = 0;
		testsPassed = 0;
		testsFailed = 0;
		loadTrace();
		traceReady = 1'b1;
		if (nameQ.size() == 0) begin
			$display("The trace holds no test lines");
			$display("Errors found");
		end else begin
			// Reset spans four rising edges, released by the first trace line
			repeat (4) @(posedge clk);
			runTrace();
			$display("Summary: %0d tests passed, %0d tests failed, %0d mismatches",
				testsPassed, testsFailed, errorCount);
			if (errorCount == 0) begin
				$display("No errors");
			end else begin
				$display("Errors found");
			end
		end
		$finish;
	end

	// Twice the trace length plus the reset time
	initial begin
		wait (traceReady === 1'b1);
		#(nameQ.size() * 20 + 40);
		$display("Timeout: the trace did not finish in the expected time");
		$display("Errors found");
		$finish;
	end

endmodule

// File: verification/controlUnit_testdata.txt
# test reset ins acq z1 z2 | expected aluOp busSelect pointerSelect memCtrl wrtEn incEn rstEn
# All hex; masks are 14 bits with bit 0 = PC up to bit 13 = AC
fetchRstAll 0 01 0 0 0 0 0 0 1 0000 0000 0000
fetchRstAll 0 01 0 0 0 0 0 0 1 0000 0000 0000
fetchRstAll 0 01 0 0 0 0 0 0 1 0000 0000 0000
fetchRstAll 0 01 1 0 0 0 0 0 1 0000 0000 0000
fetchRstAll 0 01 0 0 0 0 0 0 0 0002 0001 0000
fetchRstAll 0 01 0 0 0 0 0 0 0 0000 0000 3ffc
rstRp 0 07 1 0 0 0 0 0 1 0000 0000 0000
rstRp 0 07 0 0 0 0 0 0 0 0002 0001 0000
rstRp 0 07 0 0 0 0 0 0 0 0000 0000 0008
incStp 0 0d 1 0 0 0 0 0 1 0000 0000 0000
incStp 0 0d 0 0 0 0 0 0 0 0002 0001 0000
incStp 0 0d 0 0 0 0 0 0 0 0000 0020 0000
movCid 0 13 1 0 0 0 0 0 1 0000 0000 0000
movCid 0 13 0 0 0 0 0 0 0 0002 0001 0000
movCid 0 13 0 0 0 0 0 0 0 0040 0000 0000
movStpAc 0 17 1 0 0 0 0 0 1 0000 0000 0000
movStpAc 0 17 0 0 0 0 0 0 0 0002 0001 0000
movStpAc 0 17 0 0 0 0 6 0 0 2000 0000 0000
ldAddr 0 18 1 0 0 0 0 0 1 0000 0000 0000
ldAddr 0 18 0 0 0 0 0 0 0 0002 0001 0000
ldAddr 0 18 0 0 0 0 0 0 2 0000 0000 0000
ldAddr 0 18 0 0 0 0 0 0 2 0000 0000 0000
ldAddr 0 18 1 0 0 0 0 0 2 0000 0000 0000
ldAddr 0 18 0 0 0 0 1 0 0 1000 0000 0000
ldAc 0 19 1 0 0 0 0 0 1 0000 0000 0000
ldAc 0 19 0 0 0 0 0 0 0 0002 0001 0000
ldAc 0 19 1 0 0 0 0 0 2 0000 0000 0000
ldAc 0 19 0 0 0 0 1 0 0 2000 0000 0000
ldRp 0 1a 1 0 0 0 0 0 1 0000 0000 0000
ldRp 0 1a 0 0 0 0 0 0 0 0002 0001 0000
ldRp 0 1a 0 0 0 0 0 1 2 0000 0000 0000
ldRp 0 1a 1 0 0 0 0 1 2 0000 0000 0000
ldRp 0 1a 0 0 0 0 1 0 0 0008 0000 0000
ldCp 0 1b 1 0 0 0 0 0 1 0000 0000 0000
ldCp 0 1b 0 0 0 0 0 0 0 0002 0001 0000
ldCp 0 1b 1 0 0 0 0 2 2 0000 0000 0000
ldCp 0 1b 0 0 0 0 1 0 0 2000 0000 0000
stSp 0 1c 1 0 0 0 0 0 1 0000 0000 0000
stSp 0 1c 0 0 0 0 0 0 0 0002 0001 0000
stSp 0 1c 0 0 0 0 0 3 3 0000 0000 0000
stSp 0 1c 1 0 0 0 0 3 3 0000 0000 0000
add 0 1d 1 0 0 0 0 0 1 0000 0000 0000
add 0 1d 0 0 0 0 0 0 0 0002 0001 0000
add 0 1d 0 0 0 1 2 0 0 0000 0000 0000
jmpz1Taken 0 1e 1 1 0 0 0 0 1 0000 0000 0000
jmpz1Taken 0 1e 0 1 0 0 0 0 0 0002 0001 0000
jmpz1Taken 0 1e 0 1 0 0 0 0 0 0000 0000 0000
jmpz1Taken 0 1e 0 1 0 0 0 0 0 0002 0000 0000
jmpz1Taken 0 1e 0 1 0 0 0 0 0 0001 0000 0000
jmpz1Taken 0 1e 0 1 0 0 0 0 0 0000 0000 0000
jmpz1Skip 0 1e 1 0 0 0 0 0 1 0000 0000 0000
jmpz1Skip 0 1e 0 0 0 0 0 0 0 0002 0001 0000
jmpz1Skip 0 1e 0 0 0 0 0 0 0 0000 0000 0000
jmpz1Skip 0 1e 0 0 0 0 0 0 0 0002 0001 0000
jmpz1Skip 0 1e 0 0 0 0 0 0 0 0000 0000 0000
jmpz2Taken 0 1f 1 0 0 0 0 0 1 0000 0000 0000
jmpz2Taken 0 1f 0 0 0 0 0 0 0 0002 0001 0000
jmpz2Taken 0 1f 0 0 0 0 0 0 0 0000 0000 0000
jmpz2Taken 0 1f 0 0 0 0 0 0 0 0002 0000 0000
jmpz2Taken 0 1f 0 0 0 0 0 0 0 0001 0000 0000
jmpz2Taken 0 1f 0 0 0 0 0 0 0 0000 0000 0000
jmpz2Skip 0 1f 1 0 1 0 0 0 1 0000 0000 0000
jmpz2Skip 0 1f 0 0 1 0 0 0 0 0002 0001 0000
jmpz2Skip 0 1f 0 0 1 0 0 0 0 0000 0000 0000
jmpz2Skip 0 1f 0 0 1 0 0 0 0 0002 0001 0000
jmpz2Skip 0 1f 0 0 1 0 0 0 0 0000 0000 0000
jmp 0 20 1 0 0 0 0 0 1 0000 0000 0000
jmp 0 20 0 0 0 0 0 0 0 0002 0001 0000
jmp 0 20 0 0 0 0 0 0 0 0000 0000 0000
jmp 0 20 0 0 0 0 0 0 0 0000 0000 0000
jmp 0 20 0 0 0 0 0 0 0 0001 0000 0000
jmp 0 20 0 0 0 0 0 0 0 0000 0000 0000
halt 0 21 1 0 0 0 0 0 1 0000 0000 0000
halt 0 21 0 0 0 0 0 0 0 0002 0001 0000
halt 0 21 0 0 0 0 0 0 0 0000 0000 0000
halt 0 21 1 0 0 0 0 0 0 0000 0000 0000
halt 1 21 0 0 0 0 0 0 0 0000 0000 0000
undefOp 0 ff 1 0 0 0 0 0 1 0000 0000 0000
undefOp 0 ff 0 0 0 0 0 0 0 0002 0001 0000
undefOp 0 ff 1 0 0 0 0 0 0 0000 0000 0000
undefOp 0 ff 0 0 0 0 0 0 0 0000 0000 0000
undefOp 1 ff 1 0 0 0 0 0 0 0000 0000 0000
undefOp 0 ff 0 0 0 0 0 0 1 0000 0000 0000

// File: flist.f
+incdir+hw
hw/controlPkg.sv
hw/opcodeDecoder.sv
hw/controlSequencer.sv
hw/controlWordTable.sv
hw/controlUnit.sv
verification/controlUnitTb.sv

// File: Bender.yml
package:
  name: control_unit

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/controlPkg.sv
      - hw/opcodeDecoder.sv
      - hw/controlSequencer.sv
      - hw/controlWordTable.sv
      - hw/controlUnit.sv
  - target: test
    files:
      - verification/controlUnitTb.sv
